/* source/cnn_input_pkg.sv */
// mnist input path definitions
package cnn_input_pkg;

  // image geometry, q16.16 pixels
  localparam int DATA_WIDTH = 32;
  localparam int FRAC_WIDTH = 16;
  localparam int N_ROWS = 28;
  localparam int N_COLS = 28;
  localparam int N_CHANNELS = 3;
  localparam int CHANNEL_PIXELS = N_ROWS * N_COLS;  // 784
  localparam int IMAGE_WORDS = N_CHANNELS * CHANNEL_PIXELS;  // 2352
  localparam int RAM_ADDR_WIDTH = 12;
  localparam int CHANNEL_WIDTH = 2;
  localparam int APB_ADDR_WIDTH = 8;

  // apb register map
  localparam logic [APB_ADDR_WIDTH-1:0] CTRL_OFFSET = 8'h00;  // write only
  localparam logic [APB_ADDR_WIDTH-1:0] STATUS_OFFSET = 8'h04;  // read only
  localparam logic [APB_ADDR_WIDTH-1:0] PIXEL_OFFSET = 8'h08;  // appends one word

  // host side states
  localparam int LOADER_STATE_WIDTH = 2;
  localparam logic [LOADER_STATE_WIDTH-1:0] LOAD_S = 2'd0;
  localparam logic [LOADER_STATE_WIDTH-1:0] RUN_S = 2'd1;
  localparam logic [LOADER_STATE_WIDTH-1:0] DONE_S = 2'd2;

  // channel sequencer states
  localparam int SEQ_STATE_WIDTH = 2;
  localparam logic [SEQ_STATE_WIDTH-1:0] FETCH_S = 2'd0;
  localparam logic [SEQ_STATE_WIDTH-1:0] STREAM_S = 2'd1;
  localparam logic [SEQ_STATE_WIDTH-1:0] WAIT_RELEASE_S = 2'd2;

  // one apb write word, read as pixel or as control
  typedef union packed {
    struct packed signed {
      logic [DATA_WIDTH-FRAC_WIDTH-1:0] int_part;
      logic [FRAC_WIDTH-1:0] frac_part;
    } pixel;
    struct packed {
      logic [DATA_WIDTH-3:0] reserved;
      logic frame_ack;  // bit 1
      logic start;  // bit 0
    } ctrl;
  } apb_wdata_u;

endpackage

/* source/apb_image_loader.sv */
// apb image loader
`timescale 1ns/1ps
module apb_image_loader (
  input  logic                                     system_clock,
  input  logic                                     global_reset,
  input  logic                                     psel_i,
  input  logic                                     penable_i,
  input  logic                                     pwrite_i,
  input  logic [cnn_input_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
  input  cnn_input_pkg::apb_wdata_u                pwdata_i,
  input  logic                                     frame_done_i,
  output logic [cnn_input_pkg::DATA_WIDTH-1:0]     prdata_o,
  output logic                                     pready_o,
  output logic                                     pslverr_o,
  output logic                                     ram_wr_en_o,
  output logic [cnn_input_pkg::RAM_ADDR_WIDTH-1:0] ram_wr_addr_o,
  output logic [cnn_input_pkg::DATA_WIDTH-1:0]     ram_wr_data_o,
  output logic                                     frame_run_o,
  output logic                                     frame_restart_o
);
  import cnn_input_pkg::*;

  logic [LOADER_STATE_WIDTH-1:0] state;
  logic [RAM_ADDR_WIDTH-1:0] wr_ptr;  // next pixel slot
  logic done_flag;
  logic access;
  logic wr_access;
  logic is_ctrl;
  logic is_status;
  logic is_pixel;
  logic image_full;
  logic pixel_ok;
  logic pixel_accept;
  logic start_req;
  logic ack_req;
  logic [DATA_WIDTH-1:0] status_word;

  assign access = psel_i & penable_i;  // second apb phase
  assign wr_access = access & pwrite_i;

  assign is_ctrl = (paddr_i == CTRL_OFFSET);
  assign is_status = (paddr_i == STATUS_OFFSET);
  assign is_pixel = (paddr_i == PIXEL_OFFSET);

  assign image_full = (wr_ptr == RAM_ADDR_WIDTH'(IMAGE_WORDS));
  assign pixel_ok = (state == LOAD_S) & ~image_full;
  assign pixel_accept = wr_access & is_pixel & pixel_ok;

  assign start_req = wr_access & is_ctrl & pwdata_i.ctrl.start;
  assign ack_req = wr_access & is_ctrl & pwdata_i.ctrl.frame_ack;

  // no wait states
  assign pready_o = access;
  assign pslverr_o = access & (~(is_ctrl | is_status | is_pixel) |
                               (pwrite_i & is_pixel & ~pixel_ok));

  always_comb begin
    status_word = '0;
    status_word[1:0] = state;
    status_word[2] = done_flag;
    status_word[27:16] = wr_ptr;
  end

  assign prdata_o = (is_status && !pwrite_i) ? status_word : '0;

  assign frame_run_o = (state == RUN_S);

  always_ff @(posedge system_clock or posedge global_reset) begin
    if (global_reset) begin
      state           <= LOAD_S;
      wr_ptr          <= '0;
      done_flag       <= 1'b0;
      ram_wr_en_o     <= 1'b0;
      frame_restart_o <= 1'b0;
    end else begin
      ram_wr_en_o     <= 1'b0;
      frame_restart_o <= 1'b0;
      case (state)
        LOAD_S: begin
          if (pixel_accept) begin
            ram_wr_en_o <= 1'b1;
            wr_ptr      <= wr_ptr + 1'b1;
          end else if (start_req && image_full) begin
            state <= RUN_S;  // start ignored on a partial image
          end
        end

        RUN_S: begin
          if (frame_done_i) begin
            state     <= DONE_S;
            done_flag <= 1'b1;
          end
        end

        DONE_S: begin
          if (ack_req) begin
            state           <= LOAD_S;
            wr_ptr          <= '0;
            done_flag       <= 1'b0;
            frame_restart_o <= 1'b1;  // rearm sequencer
          end
        end

        default: state <= LOAD_S;
      endcase
    end
  end

  // write port payload follows ram_wr_en_o by construction
  always_ff @(posedge system_clock) begin
    if (pixel_accept) begin
      ram_wr_addr_o <= wr_ptr;
      ram_wr_data_o <= pwdata_i.pixel;
    end
  end

endmodule

/* source/image_ram.sv */
// image memory
`timescale 1ns/1ps
module image_ram (
  input  logic                                     system_clock,
  input  logic                                     wr_en_i,
  input  logic [cnn_input_pkg::RAM_ADDR_WIDTH-1:0] wr_addr_i,
  input  logic [cnn_input_pkg::DATA_WIDTH-1:0]     wr_data_i,
  input  logic [cnn_input_pkg::RAM_ADDR_WIDTH-1:0] rd_addr_i,
  output logic [cnn_input_pkg::DATA_WIDTH-1:0]     rd_data_o
);
  import cnn_input_pkg::*;

  // three channels back to back, 784 words each
  logic [DATA_WIDTH-1:0] mem [IMAGE_WORDS];

  always_ff @(posedge system_clock) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge system_clock) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

/* source/channel_sequencer.sv */
// input channel sequencer
`timescale 1ns/1ps
module channel_sequencer (
  input  logic                                     system_clock,
  input  logic                                     global_reset,
  input  logic                                     frame_run_i,
  input  logic                                     frame_restart_i,
  input  logic [cnn_input_pkg::DATA_WIDTH-1:0]     ram_rd_data_i,
  input  logic                                     hold_i,
  output logic [cnn_input_pkg::RAM_ADDR_WIDTH-1:0] ram_rd_addr_o,
  output logic [cnn_input_pkg::DATA_WIDTH-1:0]     pixel_o,
  output logic [cnn_input_pkg::CHANNEL_WIDTH-1:0]  channel_o,
  output logic                                     pixel_valid_o,
  output logic                                     frame_done_o
);
  import cnn_input_pkg::*;

  logic [SEQ_STATE_WIDTH-1:0] state;
  logic [CHANNEL_WIDTH-1:0] cur_ch;
  logic [CHANNEL_WIDTH-1:0] next_ch;
  logic [RAM_ADDR_WIDTH-1:0] rd_ptr [N_CHANNELS];  // next word not yet loaded
  logic [DATA_WIDTH-1:0] data_reg [N_CHANNELS];
  logic [N_CHANNELS-1:0] full;  // data_reg holds an unsent pixel
  logic [N_CHANNELS-1:0] more;  // words left in memory
  logic [N_CHANNELS-1:0] has_pixels;
  logic [RAM_ADDR_WIDTH-1:0] xfer_count;
  logic primed;  // read data matches rd_ptr of cur_ch
  logic fetch_go;
  logic load_first;
  logic xfer;
  logic advance;

  // first channel after cur with pixels left, else cur itself
  function automatic logic [CHANNEL_WIDTH-1:0] next_channel(
    input logic [CHANNEL_WIDTH-1:0] cur,
    input logic [N_CHANNELS-1:0]    avail
  );
    logic [CHANNEL_WIDTH-1:0] pick;
    int cand;
    pick = cur;
    for (int k = N_CHANNELS - 1; k >= 1; k--) begin
      cand = (int'(cur) + k) % N_CHANNELS;
      if (avail[cand]) begin
        pick = CHANNEL_WIDTH'(cand);  // lowest offset wins
      end
    end
    return pick;
  endfunction

  always_comb begin
    for (int c = 0; c < N_CHANNELS; c++) begin
      more[c] = (rd_ptr[c] != RAM_ADDR_WIDTH'((c + 1) * CHANNEL_PIXELS));
      has_pixels[c] = full[c] | more[c];
    end
  end

  assign next_ch = next_channel(cur_ch, has_pixels);

  assign fetch_go = (state == FETCH_S) & frame_run_i & has_pixels[cur_ch];
  assign load_first = fetch_go & primed & ~full[cur_ch];
  assign xfer = pixel_valid_o & ~hold_i;
  assign advance = load_first | (xfer & more[cur_ch]);

  // lead the address so the next word is ready for back to back sends
  assign ram_rd_addr_o = rd_ptr[cur_ch] + RAM_ADDR_WIDTH'(advance);
  assign pixel_o = data_reg[cur_ch];
  assign channel_o = cur_ch;

  always_ff @(posedge system_clock or posedge global_reset) begin
    if (global_reset) begin
      state         <= FETCH_S;
      cur_ch        <= '0;
      primed        <= 1'b0;
      full          <= '0;
      pixel_valid_o <= 1'b0;
      xfer_count    <= '0;
      frame_done_o  <= 1'b0;
      for (int c = 0; c < N_CHANNELS; c++) begin
        rd_ptr[c] <= RAM_ADDR_WIDTH'(c * CHANNEL_PIXELS);
      end
    end else if (frame_restart_i) begin
      state         <= FETCH_S;
      cur_ch        <= '0;
      primed        <= 1'b0;
      full          <= '0;
      pixel_valid_o <= 1'b0;
      xfer_count    <= '0;
      frame_done_o  <= 1'b0;
      for (int c = 0; c < N_CHANNELS; c++) begin
        rd_ptr[c] <= RAM_ADDR_WIDTH'(c * CHANNEL_PIXELS);
      end
    end else begin
      frame_done_o <= 1'b0;
      if (advance) begin
        rd_ptr[cur_ch] <= rd_ptr[cur_ch] + 1'b1;
      end
      if (xfer) begin
        xfer_count   <= xfer_count + 1'b1;
        frame_done_o <= (xfer_count == RAM_ADDR_WIDTH'(IMAGE_WORDS - 1));
      end

      case (state)
        FETCH_S: begin
          if (!fetch_go) begin
            primed <= 1'b0;  // idle or channel empty
          end else if (full[cur_ch] || primed) begin
            full[cur_ch]  <= 1'b1;
            primed        <= 1'b0;
            pixel_valid_o <= 1'b1;
            state         <= STREAM_S;
          end else begin
            primed <= 1'b1;  // first word in flight
          end
        end

        STREAM_S: begin
          if (hold_i) begin
            pixel_valid_o <= 1'b0;  // pixel stays in data_reg
            cur_ch        <= next_ch;
            state         <= WAIT_RELEASE_S;
          end else if (!more[cur_ch]) begin
            full[cur_ch]  <= 1'b0;  // last pixel of channel sent
            pixel_valid_o <= 1'b0;
            cur_ch        <= next_ch;
            state         <= FETCH_S;
          end
        end

        WAIT_RELEASE_S: begin
          if (!hold_i) begin
            state <= FETCH_S;
          end
        end

        default: state <= FETCH_S;
      endcase
    end
  end

  always_ff @(posedge system_clock) begin
    if (advance) begin
      data_reg[cur_ch] <= ram_rd_data_i;
    end
  end

endmodule

/* source/cnn_input_top.sv */
// cnn input path top
`timescale 1ns/1ps
module cnn_input_top (
  input  logic                                     system_clock,
  input  logic                                     global_reset,
  input  logic                                     psel_i,
  input  logic                                     penable_i,
  input  logic                                     pwrite_i,
  input  logic [cnn_input_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
  input  cnn_input_pkg::apb_wdata_u                pwdata_i,
  output logic [cnn_input_pkg::DATA_WIDTH-1:0]     prdata_o,
  output logic                                     pready_o,
  output logic                                     pslverr_o,
  input  logic                                     hold_i,
  output logic [cnn_input_pkg::DATA_WIDTH-1:0]     pixel_o,
  output logic [cnn_input_pkg::CHANNEL_WIDTH-1:0]  channel_o,
  output logic                                     pixel_valid_o
);
  import cnn_input_pkg::*;

  logic ram_wr_en;
  logic [RAM_ADDR_WIDTH-1:0] ram_wr_addr;
  logic [DATA_WIDTH-1:0] ram_wr_data;
  logic [RAM_ADDR_WIDTH-1:0] ram_rd_addr;
  logic [DATA_WIDTH-1:0] ram_rd_data;
  logic frame_run;
  logic frame_restart;
  logic frame_done;

  apb_image_loader u_loader (
    .system_clock   (system_clock),
    .global_reset   (global_reset),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .frame_done_i   (frame_done),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .ram_wr_en_o    (ram_wr_en),
    .ram_wr_addr_o  (ram_wr_addr),
    .ram_wr_data_o  (ram_wr_data),
    .frame_run_o    (frame_run),
    .frame_restart_o(frame_restart)
  );

  image_ram u_ram (
    .system_clock(system_clock),
    .wr_en_i     (ram_wr_en),
    .wr_addr_i   (ram_wr_addr),
    .wr_data_i   (ram_wr_data),
    .rd_addr_i   (ram_rd_addr),
    .rd_data_o   (ram_rd_data)
  );

  channel_sequencer u_seq (
    .system_clock   (system_clock),
    .global_reset   (global_reset),
    .frame_run_i    (frame_run),
    .frame_restart_i(frame_restart),
    .ram_rd_data_i  (ram_rd_data),
    .hold_i         (hold_i),
    .ram_rd_addr_o  (ram_rd_addr),
    .pixel_o        (pixel_o),
    .channel_o      (channel_o),
    .pixel_valid_o  (pixel_valid_o),
    .frame_done_o   (frame_done)
  );

endmodule

/* dv/cnn_input_sva.sv */
// input path protocol checks
`timescale 1ns/1ps
module cnn_input_sva (
  input logic                                    system_clock,
  input logic                                    global_reset,
  input logic                                    psel_i,
  input logic                                    penable_i,
  input logic                                    pready_o,
  input logic                                    pslverr_o,
  input logic                                    hold_i,
  input logic [cnn_input_pkg::CHANNEL_WIDTH-1:0] channel_o,
  input logic                                    pixel_valid_o
);
  int fail_count = 0;

  a_reset_quiet: assert property (@(posedge system_clock)
    global_reset |-> !pixel_valid_o && !pslverr_o)
  else begin
    $error("pixel_valid_o or pslverr_o high during reset");
    fail_count++;
  end

  a_post_reset_quiet: assert property (@(posedge system_clock)
    $fell(global_reset) |-> !pixel_valid_o && !pslverr_o)
  else begin
    $error("pixel_valid_o or pslverr_o high right after reset");
    fail_count++;
  end

  // channel may only change once valid has dropped
  a_channel_stable: assert property (@(posedge system_clock) disable iff (global_reset)
    pixel_valid_o |=> !pixel_valid_o || $stable(channel_o))
  else begin
    $error("channel_o changed while pixel_valid_o was high");
    fail_count++;
  end

  a_stall_drops_valid: assert property (@(posedge system_clock) disable iff (global_reset)
    pixel_valid_o && hold_i |=> !pixel_valid_o)
  else begin
    $error("pixel_valid_o stayed high after a held cycle");
    fail_count++;
  end

  a_slverr_in_access: assert property (@(posedge system_clock) disable iff (global_reset)
    pslverr_o |-> psel_i && penable_i)
  else begin
    $error("pslverr_o outside an apb access cycle");
    fail_count++;
  end

  a_ready_in_access: assert property (@(posedge system_clock) disable iff (global_reset)
    psel_i && penable_i |-> pready_o)
  else begin
    $error("pready_o low in an apb access cycle");
    fail_count++;
  end

endmodule

bind cnn_input_top cnn_input_sva u_sva (.*);

/* dv/tb_cnn_input.sv */
// input path testbench
`timescale 1ns/1ps
module tb_cnn_input;
  import cnn_input_pkg::*;

  localparam int TIMEOUT_CYCLES = 2 * (IMAGE_WORDS * 3 + IMAGE_WORDS * 4) + 1000;

  logic system_clock;
  logic global_reset;
  logic psel_i;
  logic penable_i;
  logic pwrite_i;
  logic [APB_ADDR_WIDTH-1:0] paddr_i;
  apb_wdata_u pwdata_i;
  logic [DATA_WIDTH-1:0] prdata_o;
  logic pready_o;
  logic pslverr_o;
  logic hold_i;
  logic [DATA_WIDTH-1:0] pixel_o;
  logic [CHANNEL_WIDTH-1:0] channel_o;
  logic pixel_valid_o;

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int test_base = 0;
  int cycles = 0;
  logic [31:0] rng = 32'hf9fd;
  logic [DATA_WIDTH-1:0] img [IMAGE_WORDS];  // words written this frame
  int sent [N_CHANNELS];  // transfers seen per channel
  int total = 0;
  logic [CHANNEL_WIDTH-1:0] last_ch = '0;
  logic turn_over = 1'b0;  // next transfer comes from another channel
  logic hold_en = 1'b0;
  logic [CHANNEL_WIDTH-1:0] exp_ch;
  logic err;
  logic [DATA_WIDTH-1:0] rdata;

  cnn_input_top u_dut (.*);

  always #20 system_clock = ~system_clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] expected_status(input logic [1:0] st, input logic done,
                                                  input int ptr);
    return {4'b0, 12'(ptr), 13'b0, done, st};
  endfunction

  // ascending with wrap, skipping drained channels
  function automatic logic [CHANNEL_WIDTH-1:0] next_with_pixels(input logic [1:0] from);
    logic [CHANNEL_WIDTH-1:0] cand;
    for (int k = 1; k < N_CHANNELS; k++) begin
      cand = CHANNEL_WIDTH'((from + k) % N_CHANNELS);
      if (sent[cand] < CHANNEL_PIXELS) begin
        return cand;
      end
    end
    return from;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("[FAIL] %s expected %h got %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic slverr);
    @(posedge system_clock);
    psel_i    <= 1'b1;  // setup
    penable_i <= 1'b0;
    pwrite_i  <= 1'b1;
    paddr_i   <= addr;
    pwdata_i  <= data;
    @(posedge system_clock);
    penable_i <= 1'b1;
    @(negedge system_clock);
    slverr = pslverr_o;
    @(posedge system_clock);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge system_clock);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= addr;
    @(posedge system_clock);
    penable_i <= 1'b1;
    @(negedge system_clock);
    data = prdata_o;
    @(posedge system_clock);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic fill_image();
    for (int i = 0; i < IMAGE_WORDS; i++) begin
      rng = xorshift32(rng);
      img[i] = rng;
    end
    for (int c = 0; c < N_CHANNELS; c++) begin
      sent[c] = 0;
    end
    total = 0;
    last_ch = '0;
    turn_over = 1'b0;
  endtask

  task automatic load_pixels(input int first, input int count);
    logic slverr;
    for (int i = first; i < first + count; i++) begin
      apb_write(PIXEL_OFFSET, img[i], slverr);
      check_value("pslverr_o", 32'h0, slverr);
    end
  endtask

  task automatic run_frame();
    logic slverr;
    apb_write(CTRL_OFFSET, 32'h1, slverr);
    check_value("pslverr_o", 32'h0, slverr);
    hold_en <= 1'b1;
    while (total < IMAGE_WORDS) begin
      @(posedge system_clock);
    end
    hold_en <= 1'b0;
    repeat (20) @(posedge system_clock);  // quiet window after the last pixel
    apb_read(STATUS_OFFSET, rdata);
    check_value("prdata_o", expected_status(DONE_S, 1'b1, IMAGE_WORDS), rdata);
  endtask

  task automatic report_test(input string name);
    $display("test %s: %0d errors", name, errors - test_base);
    tests++;
    test_base = errors;
  endtask

  // hold about one cycle in four
  always @(posedge system_clock) begin
    if (hold_en) begin
      rng = xorshift32(rng);
      hold_i <= (rng[1:0] == 2'b00);
    end else begin
      hold_i <= 1'b0;
    end
  end

  // stream scoreboard, sampled mid cycle
  always @(negedge system_clock) begin
    if (!global_reset && pixel_valid_o) begin
      if (total >= IMAGE_WORDS) begin
        $display("pixel_valid_o raised after the whole frame was transferred");
        errors++;
      end else if (hold_i) begin
        last_ch = channel_o;
        turn_over = 1'b1;
      end else begin
        exp_ch = turn_over ? next_with_pixels(last_ch) : last_ch;
        check_value("channel_o", exp_ch, channel_o);
        if (channel_o < N_CHANNELS && sent[channel_o] < CHANNEL_PIXELS) begin
          check_value("pixel_o", img[channel_o * CHANNEL_PIXELS + sent[channel_o]], pixel_o);
          sent[channel_o]++;
          turn_over = (sent[channel_o] == CHANNEL_PIXELS);
        end else begin
          $display("pixel transferred on channel %0d which had no pixels left", channel_o);
          errors++;
          turn_over = 1'b1;
        end
        last_ch = channel_o;
        total++;
      end
    end
  end

  always @(posedge system_clock) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    system_clock = 1'b0;
    global_reset = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    hold_i = 1'b0;
    #1 global_reset = 1'b1;
    repeat (10) @(posedge system_clock);
    global_reset <= 1'b0;

    apb_read(STATUS_OFFSET, rdata);
    check_value("prdata_o", expected_status(LOAD_S, 1'b0, 0), rdata);
    report_test("reset");

    fill_image();
    load_pixels(0, 1000);
    apb_write(CTRL_OFFSET, 32'h1, err);  // image incomplete, start ignored
    apb_read(STATUS_OFFSET, rdata);
    check_value("prdata_o", expected_status(LOAD_S, 1'b0, 1000), rdata);
    load_pixels(1000, IMAGE_WORDS - 1000);
    apb_write(PIXEL_OFFSET, 32'hdead_beef, err);
    check_value("pslverr_o", 32'h1, err);
    apb_write(8'h0c, 32'h0, err);
    check_value("pslverr_o", 32'h1, err);
    apb_read(STATUS_OFFSET, rdata);
    check_value("prdata_o", expected_status(LOAD_S, 1'b0, IMAGE_WORDS), rdata);
    report_test("apb rules");

    run_frame();
    report_test("first frame stream");

    apb_write(CTRL_OFFSET, 32'h2, err);  // frame_ack
    apb_read(STATUS_OFFSET, rdata);
    check_value("prdata_o", expected_status(LOAD_S, 1'b0, 0), rdata);
    report_test("frame ack restart");

    fill_image();
    load_pixels(0, IMAGE_WORDS);
    run_frame();
    report_test("second frame stream");

    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, checks, errors, u_dut.u_sva.fail_count);
    if (errors == 0 && u_dut.u_sva.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* all.f */
source/cnn_input_pkg.sv
source/apb_image_loader.sv
source/image_ram.sv
source/channel_sequencer.sv
source/cnn_input_top.sv
dv/cnn_input_sva.sv
dv/tb_cnn_input.sv
